// ==== filelist.f ====
design/ctrl_pkg.sv
design/obi_outstanding_tracker.sv
design/fencei_handshake.sv
design/ctrl_fsm.sv
design/core_ctrl_top.sv
verification/core_ctrl_properties.sv
verification/tb_core_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core_ctrl
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_core_ctrl.sv ====
// Core controller testbench

`timescale 1ns/1ps

module tb_core_ctrl
  import ctrl_pkg::*;
();

  localparam int WAIT_LIMIT = 50;

  logic    clk;
  logic    rst_n;
  logic    obi_req_i;
  logic    obi_gnt_i;
  logic    obi_we_i;
  logic    obi_rvalid_i;
  logic    obi_err_i;
  logic    wb_lsu_i;
  logic    wb_fencei_i;
  logic    fencei_flush_ack_i;
  logic    pc_set_o;
  pc_mux_e pc_mux_o;
  logic    nmi_pending_o;
  logic    nmi_is_store_o;
  logic    fencei_flush_req_o;
  logic    fencei_retire_o;

  logic [15:0] lfsr;
  int          errors;
  int          timeouts;
  int          traps_seen;
  int          traps_expected;
  int          assert_fails;

  core_ctrl_top u_core_ctrl_top (.*);

  bind core_ctrl_top core_ctrl_properties u_core_ctrl_properties (
    .clk(clk), .rst_n(rst_n),
    .obi_req_i(obi_req_i), .obi_gnt_i(obi_gnt_i), .obi_we_i(obi_we_i),
    .obi_rvalid_i(obi_rvalid_i), .obi_err_i(obi_err_i),
    .wb_lsu_i(wb_lsu_i), .wb_fencei_i(wb_fencei_i),
    .fencei_flush_ack_i(fencei_flush_ack_i),
    .pc_set_o(pc_set_o), .pc_mux_o(pc_mux_o),
    .nmi_pending_o(nmi_pending_o), .nmi_is_store_o(nmi_is_store_o),
    .fencei_flush_req_o(fencei_flush_req_o), .fencei_retire_o(fencei_retire_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Local checks
  ////////////////////////////////////////////////////////////

  // Outputs are looked at in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n && pc_set_o && pc_mux_o == PC_TRAP_NMI) begin
      traps_seen++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [3:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[2:0], lfsr[0]};
    end
  endtask

  task automatic bus_cycle(input logic grant, input logic we, input logic resp,
                           input logic err);
    @(posedge clk);
    obi_req_i    <= grant;
    obi_gnt_i    <= grant;
    obi_we_i     <= we;
    obi_rvalid_i <= resp;
    obi_err_i    <= err;
  endtask

  // Polls one condition per cycle until it holds or the limit runs out
  task automatic wait_for(input int which, input string what);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < WAIT_LIMIT && !hit; i++) begin
      @(negedge clk);
      case (which)
        0: hit = pc_set_o && (pc_mux_o == PC_BOOT);
        1: hit = pc_set_o && (pc_mux_o == PC_TRAP_NMI);
        2: hit = fencei_flush_req_o;
        default: hit = fencei_retire_o;
      endcase
    end
    if (!hit) begin
      timeouts++;
      $display("Timeout while waiting for %s at time %0t", what, $time);
    end
  endtask

  // One or two accesses, one errored response, then the NMI is taken
  task automatic error_episode();
    logic [3:0] r;
    int         n;
    int         err_pos;
    take_bits(1, r);
    n = 1 + int'(r[0]);
    @(posedge clk);
    wb_lsu_i <= 1'b1;
    for (int i = 0; i < n; i++) begin
      take_bits(2, r);
      // Back-pressure, a request that waits for its grant
      if (r[1]) begin
        bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        obi_req_i <= 1'b1;
      end
      bus_cycle(1'b1, r[0], 1'b0, 1'b0);
    end
    take_bits(1, r);
    err_pos = (n == 2) ? int'(r[0]) : 0;
    for (int i = 0; i < n; i++) begin
      take_bits(1, r);
      // A later error must be ignored
      bus_cycle(1'b0, 1'b0, 1'b1, (i == err_pos) || (i > err_pos && r[0]));
    end
    bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    wb_lsu_i <= 1'b0;
    traps_expected++;
    wait_for(1, "NMI trap PC set");
  endtask

  // Two accesses of opposite direction and both responses errored
  // The first error latches the older one, the second must leave it alone
  task automatic double_error_episode(input logic first_we);
    @(posedge clk);
    wb_lsu_i <= 1'b1;
    bus_cycle(1'b1, first_we, 1'b0, 1'b0);
    bus_cycle(1'b1, !first_we, 1'b0, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    wb_lsu_i <= 1'b0;
    traps_expected++;
    wait_for(1, "NMI trap PC set after two errors");
  endtask

  task automatic fence_episode();
    logic [3:0] r;
    @(posedge clk);
    wb_fencei_i <= 1'b1;
    wait_for(2, "flush request");
    take_bits(2, r);
    repeat (int'(r[1:0])) @(posedge clk);
    @(posedge clk);
    fencei_flush_ack_i <= 1'b1;
    wait_for(3, "fence.i retire");
    @(posedge clk);
    wb_fencei_i        <= 1'b0;
    fencei_flush_ack_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr               = 16'd632;
    errors             = 0;
    timeouts           = 0;
    traps_seen         = 0;
    traps_expected     = 0;
    assert_fails       = 0;
    rst_n              = 1'b0;
    obi_req_i          = 1'b0;
    obi_gnt_i          = 1'b0;
    obi_we_i           = 1'b0;
    obi_rvalid_i       = 1'b0;
    obi_err_i          = 1'b0;
    wb_lsu_i           = 1'b0;
    wb_fencei_i        = 1'b0;
    fencei_flush_ack_i = 1'b0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_for(0, "boot PC set");

    for (int i = 0; i < 12; i++) begin
      error_episode();
      repeat (2) @(posedge clk);
    end

    // Oldest entry a load behind a store, then the other way round
    double_error_episode(1'b0);
    repeat (2) @(posedge clk);
    double_error_episode(1'b1);
    repeat (2) @(posedge clk);

    for (int i = 0; i < 4; i++) begin
      fence_episode();
    end

    // NMI held off by an LSU in writeback while a fence.i waits behind it
    @(posedge clk);
    wb_lsu_i <= 1'b1;
    bus_cycle(1'b1, 1'b1, 1'b0, 1'b0);
    bus_cycle(1'b0, 1'b0, 1'b1, 1'b1);
    bus_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    wb_fencei_i <= 1'b1;
    repeat (6) begin
      @(negedge clk);
      if (fencei_flush_req_o) begin
        errors++;
        $display("MISMATCH %0t: flush request while an NMI is pending", $time);
      end
    end
    @(posedge clk);
    wb_lsu_i <= 1'b0;
    traps_expected++;
    wait_for(1, "NMI trap PC set before the flush");
    wait_for(2, "flush request after the NMI");
    @(posedge clk);
    fencei_flush_ack_i <= 1'b1;
    wait_for(3, "fence.i retire after the NMI");
    @(posedge clk);
    wb_fencei_i        <= 1'b0;
    fencei_flush_ack_i <= 1'b0;
    repeat (3) @(posedge clk);

    if (traps_seen != traps_expected) begin
      errors++;
      $display("MISMATCH %0t: %0d trap PC sets seen, %0d expected", $time,
               traps_seen, traps_expected);
    end

    assert_fails = u_core_ctrl_top.u_core_ctrl_properties.fail_count;
    $display("Closing counts: %0d mismatches, %0d assertion failures, %0d timeouts",
             errors, assert_fails, timeouts);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/core_ctrl_properties.sv ====
// Core controller assertions

`timescale 1ns/1ps

module core_ctrl_properties
  import ctrl_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    obi_req_i,
  input logic    obi_gnt_i,
  input logic    obi_we_i,
  input logic    obi_rvalid_i,
  input logic    obi_err_i,
  input logic    wb_lsu_i,
  input logic    wb_fencei_i,
  input logic    fencei_flush_ack_i,
  input logic    pc_set_o,
  input pc_mux_e pc_mux_o,
  input logic    nmi_pending_o,
  input logic    nmi_is_store_o,
  input logic    fencei_flush_req_o,
  input logic    fencei_retire_o
);

  ////////////////////////////////////////////////////////////
  // Reference model of the bus
  ////////////////////////////////////////////////////////////

  logic       grant;
  logic       trap_set;
  logic       boot_set;
  logic [1:0] cnt_m;
  logic       oldest_m;
  logic       second_m;
  // Edges seen since reset, saturating at 3
  logic [1:0] cyc;

  // Number of failed assertions
  int         fail_count = 0;

  assign grant    = obi_req_i && obi_gnt_i;
  assign trap_set = pc_set_o && (pc_mux_o == PC_TRAP_NMI);
  assign boot_set = pc_set_o && (pc_mux_o == PC_BOOT);

  // Responses come back in order, so the oldest entry leaves first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_m    <= '0;
      oldest_m <= 1'b0;
      second_m <= 1'b0;
      cyc      <= '0;
    end else begin
      if (cyc != 2'd3) begin
        cyc <= cyc + 2'd1;
      end
      if (grant && !obi_rvalid_i) begin
        cnt_m <= cnt_m + 2'd1;
        if (cnt_m == 2'd0) begin
          oldest_m <= obi_we_i;
        end else begin
          second_m <= obi_we_i;
        end
      end else if (!grant && obi_rvalid_i) begin
        cnt_m    <= cnt_m - 2'd1;
        oldest_m <= second_m;
      end else if (grant && obi_rvalid_i) begin
        // One leaves and one enters
        if (cnt_m == 2'd1) begin
          oldest_m <= obi_we_i;
        end else begin
          oldest_m <= second_m;
          second_m <= obi_we_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Boot and NMI
  ////////////////////////////////////////////////////////////

  a_boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc == 2'd1) == boot_set)
    else begin
      fail_count++;
      $error("boot PC set outside its single boot cycle");
    end

  a_err_latch: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_rvalid_i && obi_err_i && !nmi_pending_o) |=>
      (nmi_pending_o && (nmi_is_store_o == $past(oldest_m))))
    else begin
      fail_count++;
      $error("bus error not latched with the oldest direction");
    end

  a_err_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (nmi_pending_o && !trap_set) |=> (nmi_pending_o && $stable(nmi_is_store_o)))
    else begin
      fail_count++;
      $error("pending NMI changed before it was taken");
    end

  a_nmi_take: assert property (@(posedge clk) disable iff (!rst_n)
    ((cyc >= 2'd2) && nmi_pending_o && !wb_lsu_i && (cnt_m == 2'd0) &&
     !fencei_flush_req_o && !trap_set) |=> trap_set)
    else begin
      fail_count++;
      $error("NMI not taken once unblocked");
    end

  a_trap_single: assert property (@(posedge clk) disable iff (!rst_n)
    trap_set |=> (!trap_set && !nmi_pending_o))
    else begin
      fail_count++;
      $error("trap PC set too long or NMI still pending");
    end

  ////////////////////////////////////////////////////////////
  // Fence.i handshake
  ////////////////////////////////////////////////////////////

  a_req_legal: assert property (@(posedge clk) disable iff (!rst_n)
    fencei_flush_req_o |-> (wb_fencei_i && (cnt_m == 2'd0)))
    else begin
      fail_count++;
      $error("flush request without fence.i or with a busy bus");
    end

  a_req_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(fencei_flush_req_o) |-> ($past(fencei_flush_ack_i) && fencei_retire_o))
    else begin
      fail_count++;
      $error("flush request fell without ack");
    end

  a_req_done: assert property (@(posedge clk) disable iff (!rst_n)
    (fencei_flush_req_o && fencei_flush_ack_i) |=> (!fencei_flush_req_o && fencei_retire_o))
    else begin
      fail_count++;
      $error("handshake did not complete after req and ack");
    end

  a_retire_src: assert property (@(posedge clk) disable iff (!rst_n)
    fencei_retire_o |-> $past(fencei_flush_req_o && fencei_flush_ack_i))
    else begin
      fail_count++;
      $error("retire without a completed handshake");
    end

  a_nmi_first: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fencei_flush_req_o) |-> !$past(nmi_pending_o))
    else begin
      fail_count++;
      $error("flush request rose while an NMI was pending");
    end

endmodule

// ==== design/core_ctrl_top.sv ====
// Core controller data side top level

`timescale 1ns/1ps

module core_ctrl_top
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // Observed data bus
  input  logic    obi_req_i,
  input  logic    obi_gnt_i,
  input  logic    obi_we_i,
  input  logic    obi_rvalid_i,
  input  logic    obi_err_i,

  // Writeback status
  input  logic    wb_lsu_i,
  input  logic    wb_fencei_i,

  // Flush acknowledge from outside
  input  logic    fencei_flush_ack_i,

  // PC set towards fetch
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,

  // NMI status
  output logic    nmi_pending_o,
  output logic    nmi_is_store_o,

  // Fence.i handshake
  output logic    fencei_flush_req_o,
  output logic    fencei_retire_o
);

  outstanding_cnt_t outstanding_cnt;
  logic             nmi_pending;
  logic             fencei_flush_req;
  logic             pc_set;
  pc_mux_e          pc_mux;

  ////////////////////////////////////////////////////////////
  // Bus tracking and error latch
  ////////////////////////////////////////////////////////////

  obi_outstanding_tracker u_obi_outstanding_tracker (
    .clk               (clk),
    .rst_n             (rst_n),
    .obi_req_i         (obi_req_i),
    .obi_gnt_i         (obi_gnt_i),
    .obi_we_i          (obi_we_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_err_i         (obi_err_i),
    .pc_set_i          (pc_set),
    .pc_mux_i          (pc_mux),
    .outstanding_cnt_o (outstanding_cnt),
    .nmi_pending_o     (nmi_pending),
    .nmi_is_store_o    (nmi_is_store_o)
  );

  ////////////////////////////////////////////////////////////
  // Flush handshake and controller
  ////////////////////////////////////////////////////////////

  fencei_handshake u_fencei_handshake (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_fencei_i        (wb_fencei_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .nmi_pending_i      (nmi_pending),
    .outstanding_cnt_i  (outstanding_cnt),
    .fencei_flush_req_o (fencei_flush_req),
    .fencei_retire_o    (fencei_retire_o)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .nmi_pending_i      (nmi_pending),
    .wb_lsu_i           (wb_lsu_i),
    .fencei_flush_req_i (fencei_flush_req),
    .outstanding_cnt_i  (outstanding_cnt),
    .pc_set_o           (pc_set),
    .pc_mux_o           (pc_mux)
  );

  // Internal nets also leave the block
  assign pc_set_o           = pc_set;
  assign pc_mux_o           = pc_mux;
  assign nmi_pending_o      = nmi_pending;
  assign fencei_flush_req_o = fencei_flush_req;

endmodule

// ==== design/ctrl_fsm.sv ====
// Core controller state machine

`timescale 1ns/1ps

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Bus error waiting to be taken
  input  logic             nmi_pending_i,

  // Load or store in writeback
  input  logic             wb_lsu_i,

  // Fence.i flush in progress
  input  logic             fencei_flush_req_i,

  // Data bus activity
  input  outstanding_cnt_t outstanding_cnt_i,

  // Registered PC set towards the fetch side
  output logic             pc_set_o,
  output pc_mux_e          pc_mux_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic        nmi_allowed;
  logic        nmi_take;
  logic        trap_set_active;
  logic        pc_set_d;
  pc_mux_e     pc_mux_d;
  logic        pc_set_q;
  pc_mux_e     pc_mux_q;

  ////////////////////////////////////////////////////////////
  // NMI gating
  ////////////////////////////////////////////////////////////

  // The NMI waits for a quiet LSU and bus and for no flush to run
  assign nmi_allowed = !wb_lsu_i && (outstanding_cnt_i == '0) && !fencei_flush_req_i;

  // The pending flag only clears at the end of the trap PC set cycle
  // Without this mask that cycle would start a second trap
  assign trap_set_active = pc_set_q && (pc_mux_q == PC_TRAP_NMI);

  assign nmi_take = (state_q == FUNCTIONAL) && nmi_pending_i && nmi_allowed &&
                    !trap_set_active;

  ////////////////////////////////////////////////////////////
  // Next state and PC set decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    pc_set_d = 1'b0;
    pc_mux_d = PC_BOOT;

    unique case (state_q)
      // First cycle out of reset does nothing but move on
      RESET: begin
        state_d  = BOOT_SET;
        // Boot PC set shows up while the state reads BOOT_SET
        pc_set_d = 1'b1;
        pc_mux_d = PC_BOOT;
      end
      BOOT_SET: begin
        state_d = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (nmi_take) begin
          pc_set_d = 1'b1;
          pc_mux_d = PC_TRAP_NMI;
        end
      end
      default: begin
        state_d = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= RESET;
      pc_set_q <= 1'b0;
      pc_mux_q <= PC_BOOT;
    end else begin
      state_q  <= state_d;
      pc_set_q <= pc_set_d;
      pc_mux_q <= pc_mux_d;
    end
  end

  assign pc_set_o = pc_set_q;
  assign pc_mux_o = pc_mux_q;

endmodule

// ==== design/fencei_handshake.sv ====
// Fence.i flush handshake

`timescale 1ns/1ps

module fencei_handshake
  import ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Fence.i sitting in writeback
  input  logic             wb_fencei_i,

  // Acknowledge from the flush target
  input  logic             fencei_flush_ack_i,

  // State that must be quiet before a flush may start
  input  logic             nmi_pending_i,
  input  outstanding_cnt_t outstanding_cnt_i,

  output logic             fencei_flush_req_o,
  output logic             fencei_retire_o
);

  logic flush_start;
  logic flush_done;
  logic flush_req_q;
  logic req_and_ack_q;

  // A flush needs an idle data bus
  // A pending NMI wins over the flush, the fence.i waits in writeback for it
  // The req-and-ack flag covers the cycle where the fence.i still sits in
  // writeback after its handshake has ended
  assign flush_start = wb_fencei_i && (outstanding_cnt_i == '0) && !nmi_pending_i &&
                       !flush_req_q && !req_and_ack_q;

  // Handshake completes in the cycle where request and ack meet
  assign flush_done = flush_req_q && fencei_flush_ack_i;

  ////////////////////////////////////////////////////////////
  // Request and completion flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_req_q   <= 1'b0;
      req_and_ack_q <= 1'b0;
    end else begin
      // Request stays up for as long as the ack keeps it waiting
      if (flush_start) begin
        flush_req_q <= 1'b1;
      end else if (flush_done) begin
        flush_req_q <= 1'b0;
      end
      // One cycle flag that follows the completing cycle
      req_and_ack_q <= flush_done;
    end
  end

  assign fencei_flush_req_o = flush_req_q;

  // The fence.i leaves writeback in the cycle after the handshake
  assign fencei_retire_o = req_and_ack_q;

endmodule

// ==== design/obi_outstanding_tracker.sv ====
// Data bus outstanding tracker

`timescale 1ns/1ps

module obi_outstanding_tracker
  import ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Observed data bus
  input  logic             obi_req_i,
  input  logic             obi_gnt_i,
  input  logic             obi_we_i,
  input  logic             obi_rvalid_i,
  input  logic             obi_err_i,

  // PC set from the controller FSM
  input  logic             pc_set_i,
  input  pc_mux_e          pc_mux_i,

  // Bus state and the latched bus error
  output outstanding_cnt_t outstanding_cnt_o,
  output logic             nmi_pending_o,
  output logic             nmi_is_store_o
);

  // A request is accepted in any cycle where req and gnt are both high
  logic             bus_grant;
  logic             dir_shift;
  logic             oldest_is_store;
  logic             err_latch;
  logic             nmi_trap_set;

  outstanding_cnt_t cnt_q;
  outstanding_dir_t dir_q;
  logic             nmi_pending_q;
  logic             nmi_is_store_q;

  assign bus_grant = obi_req_i && obi_gnt_i;

  // The older entry moves to bit 1 whenever another transaction is still
  // in flight once the new one is accepted
  // With a response in the same cycle only a full tracker keeps one behind
  assign dir_shift = obi_rvalid_i ? (cnt_q == outstanding_cnt_t'(MAX_OUTSTANDING))
                                  : (cnt_q != '0);

  // With one transaction in flight it sits in bit 0, with two the oldest is bit 1
  assign oldest_is_store = (cnt_q == outstanding_cnt_t'(MAX_OUTSTANDING)) ? dir_q[1]
                                                                           : dir_q[0];

  // Only the first error is captured while an NMI waits to be taken
  assign err_latch    = obi_rvalid_i && obi_err_i && !nmi_pending_q;
  assign nmi_trap_set = pc_set_i && (pc_mux_i == PC_TRAP_NMI);

  ////////////////////////////////////////////////////////////
  // Outstanding transaction count
  ////////////////////////////////////////////////////////////

  // A grant and a response in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (bus_grant && !obi_rvalid_i) begin
      cnt_q <= cnt_q + 2'd1;
    end else if (!bus_grant && obi_rvalid_i) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Direction flags and error direction
  ////////////////////////////////////////////////////////////

  // The flags are only meaningful below the current count
  always_ff @(posedge clk) begin
    if (bus_grant) begin
      if (dir_shift) begin
        dir_q[1] <= dir_q[0];
      end
      dir_q[0] <= obi_we_i;
    end
    // Direction of the access that failed, qualified by the pending flag
    if (err_latch) begin
      nmi_is_store_q <= oldest_is_store;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pending NMI
  ////////////////////////////////////////////////////////////

  // Set by the first bus error and held until the trap PC set is done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_q <= 1'b0;
    end else if (err_latch) begin
      nmi_pending_q <= 1'b1;
    end else if (nmi_trap_set) begin
      nmi_pending_q <= 1'b0;
    end
  end

  assign outstanding_cnt_o = cnt_q;
  assign nmi_pending_o     = nmi_pending_q;
  assign nmi_is_store_o    = nmi_is_store_q;

endmodule

// ==== design/ctrl_pkg.sv ====
// Core controller shared definitions

package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Data bus bookkeeping
  ////////////////////////////////////////////////////////////

  // Deepest pipelining of the data bus that the tracker follows
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Number of granted transactions still waiting for a response
  // Legal values run from 0 to MAX_OUTSTANDING
  typedef logic [1:0] outstanding_cnt_t;

  // Store flags of the outstanding transactions
  // Bit 0 holds the newest entry and bit 1 the oldest one
  typedef logic [1:0] outstanding_dir_t;

  ////////////////////////////////////////////////////////////
  // Controller encodings
  ////////////////////////////////////////////////////////////

  // Main controller states
  typedef enum logic [1:0] {
    RESET      = 2'b00,
    BOOT_SET   = 2'b01,
    FUNCTIONAL = 2'b10
  } ctrl_state_e;

  // PC source that goes along with a PC set
  // Only the boot address and the NMI vector exist in this controller
  typedef enum logic {
    PC_BOOT     = 1'b0,
    PC_TRAP_NMI = 1'b1
  } pc_mux_e;

endpackage
